// File: microOpPkg.sv
`default_nettype none
// **********************************************************************
// Micro-op encoding
// Op classes, sub-types, operand kinds and the packed sub-info field
// used by the issue-queue payload
// **********************************************************************
package microOpPkg;

    // Op class, which is also the issue-queue bank index
    typedef logic [1:0] mopType;
    localparam mopType MOP_TYPE_INT     = 2'd0;
    localparam mopType MOP_TYPE_COMPLEX = 2'd1;
    localparam mopType MOP_TYPE_MEM     = 2'd2;

    // Number of issue-queue banks, one per class
    localparam int QUEUE_CLASSES = 3;

    // Sub-type whose meaning depends on the class
    typedef logic [1:0] mopSubType;
    localparam mopSubType INT_SUB_ALU     = 2'd0;
    localparam mopSubType INT_SUB_SHIFT   = 2'd1;
    localparam mopSubType INT_SUB_BR      = 2'd2;
    localparam mopSubType INT_SUB_RIJ     = 2'd3;
    localparam mopSubType COMPLEX_SUB_MUL = 2'd0;
    localparam mopSubType COMPLEX_SUB_DIV = 2'd1;
    localparam mopSubType MEM_SUB_LOAD    = 2'd0;
    localparam mopSubType MEM_SUB_STORE   = 2'd1;

    // Where an operand comes from
    typedef logic [1:0] operandType;
    localparam operandType OOT_REG  = 2'd0;
    localparam operandType OOT_IMM  = 2'd1;
    localparam operandType OOT_PC   = 2'd2;
    localparam operandType OOT_ZERO = 2'd3;

    typedef logic [3:0]  aluCode;
    typedef logic [11:0] brDisp;
    typedef logic [1:0]  mulDivCode;
    typedef logic [2:0]  memAccessMode;

    // Class-specific info that the branch layout fills completely
    typedef logic [11:0] subInfo;

    // Zero padding above each narrower layout
    localparam int INT_SUB_PAD = $bits(subInfo) - 2 * $bits(operandType) - $bits(aluCode);
    localparam int MUL_SUB_PAD = $bits(subInfo) - 1 - $bits(mulDivCode);
    localparam int DIV_SUB_PAD = $bits(subInfo) - $bits(mulDivCode);
    localparam int MEM_SUB_PAD = $bits(subInfo) - $bits(mopSubType)
                                 - $bits(memAccessMode) - $bits(operandType);

endpackage
`default_nettype wire

// File: schedulerPkg.sv
`default_nettype none
// **********************************************************************
// Scheduler-side types
// Register numbers, queue and active-list pointers and the
// issue-queue payload word
// **********************************************************************
package schedulerPkg;
    import microOpPkg::*;

    typedef logic [5:0]  phyRegNum;
    typedef logic [4:0]  activeListPtr;
    typedef logic [3:0]  issueQueuePtr;

    // Low PC bits kept for branch recovery
    typedef logic [15:0] pcLow;

    // Payload word fields from the top
    //   reserved zeros, mopSubType, phySrcA, phySrcB, phyDst, writeReg,
    //   activeListPtr, pcLow, subInfo, parity
    localparam int PAYLOAD_WIDTH = 63;
    typedef logic [PAYLOAD_WIDTH-1:0] payloadWord;

    // Bits taken by the real fields and parity
    localparam int PW_USED_WIDTH = $bits(mopSubType)
                                   + 3 * $bits(phyRegNum)
                                   + 1
                                   + $bits(activeListPtr)
                                   + $bits(pcLow)
                                   + $bits(subInfo)
                                   + 1;

    // Unused top bits that are always written as zero
    localparam int PW_RESERVED_WIDTH = PAYLOAD_WIDTH - PW_USED_WIDTH;

    // Parity sits in bit 0 and makes the XOR of the whole word zero
    localparam int PW_PARITY_POS = 0;

endpackage
`default_nettype wire

// File: dispatchPipeReg.sv
`timescale 1ns/10ps
`default_nettype none
// **********************************************************************
// Dispatch pipeline register
// Captures renamed ops of every lane, holds them while stalled
// **********************************************************************
module dispatchPipeReg import microOpPkg::*, schedulerPkg::*; #(
    parameter int dispatchWidth = 2
) (
    input  logic         ctrl,
    input  logic         arstN,
    input  logic         stall,
    input  logic         opValid          [dispatchWidth],
    input  mopType       opMopType        [dispatchWidth],
    input  mopSubType    opSubType        [dispatchWidth],
    input  operandType   opTypeA          [dispatchWidth],
    input  operandType   opTypeB          [dispatchWidth],
    input  aluCode       opAluCode        [dispatchWidth],
    input  brDisp        opBrDisp         [dispatchWidth],
    input  logic         opMulUpper       [dispatchWidth],
    input  mulDivCode    opMulDivCode     [dispatchWidth],
    input  memAccessMode opMemMode        [dispatchWidth],
    input  phyRegNum     opPhySrcA        [dispatchWidth],
    input  phyRegNum     opPhySrcB        [dispatchWidth],
    input  phyRegNum     opPhyDst         [dispatchWidth],
    input  logic         opWriteReg       [dispatchWidth],
    input  activeListPtr opActiveListPtr  [dispatchWidth],
    input  issueQueuePtr opIssueQueuePtr  [dispatchWidth],
    input  pcLow         opPc             [dispatchWidth],
    output logic         regValid         [dispatchWidth],
    output mopType       regMopType       [dispatchWidth],
    output mopSubType    regSubType       [dispatchWidth],
    output operandType   regTypeA         [dispatchWidth],
    output operandType   regTypeB         [dispatchWidth],
    output aluCode       regAluCode       [dispatchWidth],
    output brDisp        regBrDisp        [dispatchWidth],
    output logic         regMulUpper      [dispatchWidth],
    output mulDivCode    regMulDivCode    [dispatchWidth],
    output memAccessMode regMemMode       [dispatchWidth],
    output phyRegNum     regPhySrcA       [dispatchWidth],
    output phyRegNum     regPhySrcB       [dispatchWidth],
    output phyRegNum     regPhyDst        [dispatchWidth],
    output logic         regWriteReg      [dispatchWidth],
    output activeListPtr regActiveListPtr [dispatchWidth],
    output issueQueuePtr regIssueQueuePtr [dispatchWidth],
    output pcLow         regPc            [dispatchWidth]
);

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dispatchWidth; i++) begin
                regValid[i]         <= 1'b0;
                regMopType[i]       <= '0;
                regSubType[i]       <= '0;
                regTypeA[i]         <= '0;
                regTypeB[i]         <= '0;
                regAluCode[i]       <= '0;
                regBrDisp[i]        <= '0;
                regMulUpper[i]      <= 1'b0;
                regMulDivCode[i]    <= '0;
                regMemMode[i]       <= '0;
                regPhySrcA[i]       <= '0;
                regPhySrcB[i]       <= '0;
                regPhyDst[i]        <= '0;
                regWriteReg[i]      <= 1'b0;
                regActiveListPtr[i] <= '0;
                regIssueQueuePtr[i] <= '0;
                regPc[i]            <= '0;
            end
        end else if (!stall) begin
            // Whole group moves together or holds
            regValid         <= opValid;
            regMopType       <= opMopType;
            regSubType       <= opSubType;
            regTypeA         <= opTypeA;
            regTypeB         <= opTypeB;
            regAluCode       <= opAluCode;
            regBrDisp        <= opBrDisp;
            regMulUpper      <= opMulUpper;
            regMulDivCode    <= opMulDivCode;
            regMemMode       <= opMemMode;
            regPhySrcA       <= opPhySrcA;
            regPhySrcB       <= opPhySrcB;
            regPhyDst        <= opPhyDst;
            regWriteReg      <= opWriteReg;
            regActiveListPtr <= opActiveListPtr;
            regIssueQueuePtr <= opIssueQueuePtr;
            regPc            <= opPc;
        end
    end

endmodule
`default_nettype wire

// File: entryFormatter.sv
`timescale 1ns/10ps
`default_nettype none
// **********************************************************************
// Issue-queue entry formatter
// Packs each registered op into a payload word with parity and
// produces write strobes, bank selects and source-valid flags
// **********************************************************************
module entryFormatter import microOpPkg::*, schedulerPkg::*; #(
    parameter int dispatchWidth = 2
) (
    input  logic                     stall,
    input  logic                     clear,
    input  logic                     regValid         [dispatchWidth],
    input  mopType                   regMopType       [dispatchWidth],
    input  mopSubType                regSubType       [dispatchWidth],
    input  operandType               regTypeA         [dispatchWidth],
    input  operandType               regTypeB         [dispatchWidth],
    input  aluCode                   regAluCode       [dispatchWidth],
    input  brDisp                    regBrDisp        [dispatchWidth],
    input  logic                     regMulUpper      [dispatchWidth],
    input  mulDivCode                regMulDivCode    [dispatchWidth],
    input  memAccessMode             regMemMode       [dispatchWidth],
    input  phyRegNum                 regPhySrcA       [dispatchWidth],
    input  phyRegNum                 regPhySrcB       [dispatchWidth],
    input  phyRegNum                 regPhyDst        [dispatchWidth],
    input  logic                     regWriteReg      [dispatchWidth],
    input  activeListPtr             regActiveListPtr [dispatchWidth],
    input  issueQueuePtr             regIssueQueuePtr [dispatchWidth],
    input  pcLow                     regPc            [dispatchWidth],
    output logic                     write            [dispatchWidth],
    output logic                     allocated        [dispatchWidth],
    output logic [QUEUE_CLASSES-1:0] queueSel         [dispatchWidth],
    output issueQueuePtr             writePtr         [dispatchWidth],
    output payloadWord               payload          [dispatchWidth],
    output logic                     srcRegValidA     [dispatchWidth],
    output logic                     srcRegValidB     [dispatchWidth]
);

    // Candidate sub-info layouts per lane
    subInfo intLayout [dispatchWidth];
    subInfo mulLayout [dispatchWidth];
    subInfo divLayout [dispatchWidth];
    subInfo memLayout [dispatchWidth];
    subInfo chosenInfo [dispatchWidth];

    // Payload without its parity bit
    logic [PAYLOAD_WIDTH-2:0] payloadBody [dispatchWidth];

    always_comb begin
        for (int i = 0; i < dispatchWidth; i++) begin
            // Strobes
            write[i]     = regValid[i] && !stall && !clear;
            allocated[i] = regValid[i];
            writePtr[i]  = regIssueQueuePtr[i];

            // Bank select follows the op class
            queueSel[i] = '0;
            queueSel[i][MOP_TYPE_INT]     = (regMopType[i] == MOP_TYPE_INT);
            queueSel[i][MOP_TYPE_COMPLEX] = (regMopType[i] == MOP_TYPE_COMPLEX);
            queueSel[i][MOP_TYPE_MEM]     = (regMopType[i] == MOP_TYPE_MEM);

            srcRegValidA[i] = (regTypeA[i] == OOT_REG);
            srcRegValidB[i] = (regTypeB[i] == OOT_REG);

            intLayout[i] = {{INT_SUB_PAD{1'b0}}, regTypeA[i], regTypeB[i], regAluCode[i]};
            mulLayout[i] = {{MUL_SUB_PAD{1'b0}}, regMulUpper[i], regMulDivCode[i]};
            divLayout[i] = {{DIV_SUB_PAD{1'b0}}, regMulDivCode[i]};
            memLayout[i] = {{MEM_SUB_PAD{1'b0}}, regSubType[i], regMemMode[i], regTypeB[i]};

            // Layout choice by class and sub-type
            case (regMopType[i])
                MOP_TYPE_INT: begin
                    if (regSubType[i] == INT_SUB_BR || regSubType[i] == INT_SUB_RIJ) begin
                        chosenInfo[i] = regBrDisp[i];
                    end else begin
                        chosenInfo[i] = intLayout[i];
                    end
                end
                MOP_TYPE_COMPLEX: begin
                    if (regSubType[i] == COMPLEX_SUB_MUL) begin
                        chosenInfo[i] = mulLayout[i];
                    end else begin
                        chosenInfo[i] = divLayout[i];
                    end
                end
                MOP_TYPE_MEM: chosenInfo[i] = memLayout[i];
                default:      chosenInfo[i] = '0;
            endcase

            payloadBody[i] = {
                {PW_RESERVED_WIDTH{1'b0}},
                regSubType[i],
                regPhySrcA[i],
                regPhySrcB[i],
                regPhyDst[i],
                regWriteReg[i],
                regActiveListPtr[i],
                regPc[i],
                chosenInfo[i]
            };

            // Even parity over the whole word
            payload[i] = {payloadBody[i], ^payloadBody[i]};
        end
    end

endmodule
`default_nettype wire

// File: issueQueuePayload.sv
`timescale 1ns/10ps
`default_nettype none
// **********************************************************************
// Issue-queue payload RAM
// One bank per queue class, per-lane writes with the higher lane
// winning, and a combinational read port with parity check
// **********************************************************************
module issueQueuePayload import microOpPkg::*, schedulerPkg::*; #(
    parameter int dispatchWidth = 2,
    parameter int queueDepth    = 16
) (
    input  logic                     ctrl,
    input  logic                     arstN,
    input  logic                     write     [dispatchWidth],
    input  logic [QUEUE_CLASSES-1:0] queueSel  [dispatchWidth],
    input  issueQueuePtr             writePtr  [dispatchWidth],
    input  payloadWord               payload   [dispatchWidth],
    input  logic [1:0]               readQueue,
    input  issueQueuePtr             readPtr,
    output payloadWord               readData,
    output logic                     readParityError
);

    payloadWord bankMem [QUEUE_CLASSES][queueDepth];

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int b = 0; b < QUEUE_CLASSES; b++) begin
                for (int e = 0; e < queueDepth; e++) begin
                    bankMem[b][e] <= '0;
                end
            end
        end else begin
            // Later lanes are applied last and so take priority
            for (int l = 0; l < dispatchWidth; l++) begin
                for (int b = 0; b < QUEUE_CLASSES; b++) begin
                    if (write[l] && queueSel[l][b]) begin
                        bankMem[b][writePtr[l]] <= payload[l];
                    end
                end
            end
        end
    end

    always_comb begin
        readData = '0;
        for (int b = 0; b < QUEUE_CLASSES; b++) begin
            if (readQueue == 2'(b)) begin
                readData = bankMem[b][readPtr];
            end
        end
    end

    // A good word XORs to zero
    assign readParityError = ^readData;

endmodule
`default_nettype wire

// File: dispatchTop.sv
`timescale 1ns/10ps
`default_nettype none
// **********************************************************************
// Dispatch stage top level
// Pipeline register, entry formatter and issue-queue payload RAM
// **********************************************************************
module dispatchTop import microOpPkg::*, schedulerPkg::*; #(
    parameter int dispatchWidth = 2,
    parameter int queueDepth    = 16
) (
    input  logic         ctrl,
    input  logic         arstN,
    input  logic         stall,
    input  logic         clear,
    input  logic         opValid         [dispatchWidth],
    input  mopType       opMopType       [dispatchWidth],
    input  mopSubType    opSubType       [dispatchWidth],
    input  operandType   opTypeA         [dispatchWidth],
    input  operandType   opTypeB         [dispatchWidth],
    input  aluCode       opAluCode       [dispatchWidth],
    input  brDisp        opBrDisp        [dispatchWidth],
    input  logic         opMulUpper      [dispatchWidth],
    input  mulDivCode    opMulDivCode    [dispatchWidth],
    input  memAccessMode opMemMode       [dispatchWidth],
    input  phyRegNum     opPhySrcA       [dispatchWidth],
    input  phyRegNum     opPhySrcB       [dispatchWidth],
    input  phyRegNum     opPhyDst        [dispatchWidth],
    input  logic         opWriteReg      [dispatchWidth],
    input  activeListPtr opActiveListPtr [dispatchWidth],
    input  issueQueuePtr opIssueQueuePtr [dispatchWidth],
    input  pcLow         opPc            [dispatchWidth],
    input  logic [1:0]   readQueue,
    input  issueQueuePtr readPtr,
    output logic         write           [dispatchWidth],
    output logic         allocated       [dispatchWidth],
    output issueQueuePtr writePtr        [dispatchWidth],
    output logic         srcRegValidA    [dispatchWidth],
    output logic         srcRegValidB    [dispatchWidth],
    output payloadWord   readData,
    output logic         readParityError
);

    // Registered lane fields
    logic         regValid         [dispatchWidth];
    mopType       regMopType       [dispatchWidth];
    mopSubType    regSubType       [dispatchWidth];
    operandType   regTypeA         [dispatchWidth];
    operandType   regTypeB         [dispatchWidth];
    aluCode       regAluCode       [dispatchWidth];
    brDisp        regBrDisp        [dispatchWidth];
    logic         regMulUpper      [dispatchWidth];
    mulDivCode    regMulDivCode    [dispatchWidth];
    memAccessMode regMemMode       [dispatchWidth];
    phyRegNum     regPhySrcA       [dispatchWidth];
    phyRegNum     regPhySrcB       [dispatchWidth];
    phyRegNum     regPhyDst        [dispatchWidth];
    logic         regWriteReg      [dispatchWidth];
    activeListPtr regActiveListPtr [dispatchWidth];
    issueQueuePtr regIssueQueuePtr [dispatchWidth];
    pcLow         regPc            [dispatchWidth];

    // Formatter to RAM
    logic [QUEUE_CLASSES-1:0] queueSel [dispatchWidth];
    payloadWord               payload  [dispatchWidth];

    dispatchPipeReg #(
        .dispatchWidth(dispatchWidth)
    ) uPipeReg (.*);

    entryFormatter #(
        .dispatchWidth(dispatchWidth)
    ) uFormatter (.*);

    issueQueuePayload #(
        .dispatchWidth(dispatchWidth),
        .queueDepth   (queueDepth)
    ) uPayloadRam (.*);

endmodule
`default_nettype wire

// File: dispatch_sva.sv
`timescale 1ns/10ps
`default_nettype none
// **********************************************************************
// Dispatch assertions
// Reset, stall, clear and strobe rules on the dispatch top level
// **********************************************************************
module dispatchSva import microOpPkg::*; #(
    parameter int dispatchWidth = 2
) (
    input logic                     ctrl,
    input logic                     arstN,
    input logic                     stall,
    input logic                     clear,
    input logic                     write     [dispatchWidth],
    input logic                     allocated [dispatchWidth],
    input logic [QUEUE_CLASSES-1:0] queueSel  [dispatchWidth]
);

    for (genvar i = 0; i < dispatchWidth; i++) begin : laneCheck
        noWriteInReset: assert property (@(posedge ctrl) !arstN |-> !write[i])
            else $error("write[%0d] high during reset", i);

        writeNeedsAlloc: assert property (@(posedge ctrl) disable iff (!arstN)
            write[i] |-> allocated[i])
            else $error("write[%0d] without allocated", i);

        // Back-pressure and flush both block the RAM write
        blockedWrite: assert property (@(posedge ctrl) disable iff (!arstN)
            (stall || clear) |-> !write[i])
            else $error("write[%0d] high under stall or clear", i);

        oneHotSel: assert property (@(posedge ctrl) disable iff (!arstN)
            write[i] |-> $onehot(queueSel[i]))
            else $error("queueSel[%0d] not one-hot on write", i);
    end

endmodule

bind dispatchTop dispatchSva #(
    .dispatchWidth(dispatchWidth)
) svaCheck (
    .ctrl     (ctrl),
    .arstN    (arstN),
    .stall    (stall),
    .clear    (clear),
    .write    (write),
    .allocated(allocated),
    .queueSel (queueSel)
);
`default_nettype wire

// File: dispatchChecker.sv
`timescale 1ns/10ps
`default_nettype none
// **********************************************************************
// Dispatch checker
// Compares DUT strobes and read port with the testbench model and
// keeps per-test and total counts
// **********************************************************************
module dispatchChecker import schedulerPkg::*; #(
    parameter int dispatchWidth = 2
) (
    input  logic         write        [dispatchWidth],
    input  logic         allocated    [dispatchWidth],
    input  issueQueuePtr writePtr     [dispatchWidth],
    input  logic         srcRegValidA [dispatchWidth],
    input  logic         srcRegValidB [dispatchWidth],
    input  payloadWord   readData,
    input  logic         readParityError,
    output int           errorCount
);

    int checkCount;
    int testChecks;
    int testErrors;
    int testCount;

    task automatic compareValue(input string testName, input string what,
                                input logic [63:0] expected, input logic [63:0] actual);
        checkCount++;
        testChecks++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("FAILED %s %s: expected %0h, actual %0h", testName, what, expected, actual);
        end
    endtask

    // Lane strobes as seen in the current cycle
    task automatic checkStrobes(input string testName, input int lane, input logic expWrite,
                                input logic expAlloc, input issueQueuePtr expPtr,
                                input logic expSrcA, input logic expSrcB);
        compareValue(testName, $sformatf("write[%0d]", lane), 64'(expWrite), 64'(write[lane]));
        compareValue(testName, $sformatf("allocated[%0d]", lane), 64'(expAlloc),
                     64'(allocated[lane]));
        compareValue(testName, $sformatf("writePtr[%0d]", lane), 64'(expPtr),
                     64'(writePtr[lane]));
        compareValue(testName, $sformatf("srcRegValidA[%0d]", lane), 64'(expSrcA),
                     64'(srcRegValidA[lane]));
        compareValue(testName, $sformatf("srcRegValidB[%0d]", lane), 64'(expSrcB),
                     64'(srcRegValidB[lane]));
    endtask

    task automatic checkRead(input string testName, input payloadWord expData);
        compareValue(testName, "readData", 64'(expData), 64'(readData));
        compareValue(testName, "parity bit", 64'(expData[0]), 64'(readData[0]));
        compareValue(testName, "readParityError", 64'(1'b0), 64'(readParityError));
    endtask

    task automatic reportProblem(input string message);
        errorCount++;
        testErrors++;
        $display("%s", message);
    endtask

    task automatic endTest(input string testName);
        $display("Test %s: %0d checks, %0d errors", testName, testChecks, testErrors);
        testCount++;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic printSummary();
        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    endtask

endmodule
`default_nettype wire

// File: tbDispatch.sv
`timescale 1ns/10ps
`default_nettype none
// **********************************************************************
// Dispatch stage testbench
// Random two-lane ops with stall and clear against mirror banks
// **********************************************************************
module tbDispatch
    import microOpPkg::*, schedulerPkg::*;
();

    localparam int LANES = 2;
    localparam int DEPTH = 16;

    logic         ctrl;
    logic         arstN;
    logic         stall;
    logic         clear;
    logic         opValid [LANES];
    mopType       opMopType [LANES];
    mopSubType    opSubType [LANES];
    operandType   opTypeA [LANES];
    operandType   opTypeB [LANES];
    aluCode       opAluCode [LANES];
    brDisp        opBrDisp [LANES];
    logic         opMulUpper [LANES];
    mulDivCode    opMulDivCode [LANES];
    memAccessMode opMemMode [LANES];
    phyRegNum     opPhySrcA [LANES];
    phyRegNum     opPhySrcB [LANES];
    phyRegNum     opPhyDst [LANES];
    logic         opWriteReg [LANES];
    activeListPtr opActiveListPtr [LANES];
    issueQueuePtr opIssueQueuePtr [LANES];
    pcLow         opPc [LANES];
    logic [1:0]   readQueue;
    issueQueuePtr readPtr;
    logic         write [LANES];
    logic         allocated [LANES];
    issueQueuePtr writePtr [LANES];
    logic         srcRegValidA [LANES];
    logic         srcRegValidB [LANES];
    payloadWord   readData;
    logic         readParityError;
    int           errorCount;

    // Model of the pipeline register and the three banks
    logic         modelValid [LANES];
    payloadWord   modelPayload [LANES];
    mopType       modelBank [LANES];
    issueQueuePtr modelPtr [LANES];
    logic         modelSrcA [LANES];
    logic         modelSrcB [LANES];
    payloadWord   mirrorBank [QUEUE_CLASSES][DEPTH];
    logic [31:0]  lfsrState;

    dispatchTop #(
        .dispatchWidth(LANES),
        .queueDepth   (DEPTH)
    ) dut_i (.*);

    dispatchChecker #(
        .dispatchWidth(LANES)
    ) scoreboard (.*);

    always #10 ctrl = ~ctrl;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic void randomOp(input int l);
        logic [1:0] cls;
        cls = 2'(takeBits(2));
        if (cls == 2'd3) begin
            cls = 2'(takeBits(1));
        end
        opMopType[l]       = cls;
        opSubType[l]       = (cls == MOP_TYPE_INT) ? 2'(takeBits(2)) : 2'(takeBits(1));
        opTypeA[l]         = 2'(takeBits(2));
        opTypeB[l]         = 2'(takeBits(2));
        opAluCode[l]       = 4'(takeBits(4));
        opBrDisp[l]        = 12'(takeBits(12));
        opMulUpper[l]      = takeBits(1) != 0;
        opMulDivCode[l]    = 2'(takeBits(2));
        opMemMode[l]       = 3'(takeBits(3));
        opPhySrcA[l]       = 6'(takeBits(6));
        opPhySrcB[l]       = 6'(takeBits(6));
        opPhyDst[l]        = 6'(takeBits(6));
        opWriteReg[l]      = takeBits(1) != 0;
        opActiveListPtr[l] = 5'(takeBits(5));
        opPc[l]            = 16'(takeBits(16));
        // Lanes differ in the top pointer bit and never collide
        opIssueQueuePtr[l] = (l == 0) ? 4'(takeBits(4))
                                      : {~opIssueQueuePtr[0][3], 3'(takeBits(3))};
    endfunction

    function automatic payloadWord expectedPayload(input int l);
        subInfo info;
        logic [61:0] body;
        case (opMopType[l])
            MOP_TYPE_INT:
                info = (opSubType[l] == INT_SUB_BR || opSubType[l] == INT_SUB_RIJ)
                     ? opBrDisp[l] : {4'b0, opTypeA[l], opTypeB[l], opAluCode[l]};
            MOP_TYPE_COMPLEX:
                info = (opSubType[l] == COMPLEX_SUB_MUL)
                     ? {9'b0, opMulUpper[l], opMulDivCode[l]} : {10'b0, opMulDivCode[l]};
            default:
                info = {5'b0, opSubType[l], opMemMode[l], opTypeB[l]};
        endcase
        body = {8'b0, opSubType[l], opPhySrcA[l], opPhySrcB[l], opPhyDst[l], opWriteReg[l],
                opActiveListPtr[l], opPc[l], info};
        return {body, ^body};
    endfunction

    function automatic void loadModel();
        for (int l = 0; l < LANES; l++) begin
            modelValid[l]   = opValid[l];
            modelPayload[l] = expectedPayload(l);
            modelBank[l]    = opMopType[l];
            modelPtr[l]     = opIssueQueuePtr[l];
            modelSrcA[l]    = (opTypeA[l] == OOT_REG);
            modelSrcB[l]    = (opTypeB[l] == OOT_REG);
        end
    endfunction

    // Drive one cycle and check it before modelling the edge
    task automatic stepCycle(input string testName, input logic [1:0] opMask,
                             input logic collide, input logic stallIn, input logic clearIn,
                             input logic [1:0] rq, input issueQueuePtr rp);
        @(negedge ctrl);
        for (int l = 0; l < LANES; l++) begin
            opValid[l] = opMask[l];
            if (opMask[l]) begin
                randomOp(l);
            end
        end
        if (collide) begin
            opMopType[1]       = opMopType[0];
            opIssueQueuePtr[1] = opIssueQueuePtr[0];
        end
        stall     = stallIn;
        clear     = clearIn;
        readQueue = rq;
        readPtr   = rp;
        #2;
        for (int l = 0; l < LANES; l++) begin
            scoreboard.checkStrobes(testName, l, modelValid[l] && !stallIn && !clearIn,
                                    modelValid[l], modelPtr[l], modelSrcA[l], modelSrcB[l]);
        end
        scoreboard.checkRead(testName, mirrorBank[rq][rp]);
        // Higher lane applied last
        for (int l = 0; l < LANES; l++) begin
            if (modelValid[l] && !stallIn && !clearIn) begin
                mirrorBank[modelBank[l]][modelPtr[l]] = modelPayload[l];
            end
        end
        if (!stallIn) begin
            loadModel();
        end
    endtask

    task automatic readAll(input string testName);
        for (int b = 0; b < QUEUE_CLASSES; b++) begin
            for (int e = 0; e < DEPTH; e++) begin
                stepCycle(testName, 2'b00, 1'b0, 1'b0, 1'b0, 2'(b), 4'(e));
            end
        end
    endtask

    task automatic waitForWrite(input string testName);
        int cycles;
        cycles = 0;
        stepCycle(testName, 2'b00, 1'b0, 1'b0, 1'b0, 2'd0, 4'd0);
        while (!write[0] && cycles < 8) begin
            stepCycle(testName, 2'b00, 1'b0, 1'b0, 1'b0, 2'd0, 4'd0);
            cycles++;
        end
        if (!write[0]) begin
            scoreboard.reportProblem($sformatf("%s: write never rose after stall dropped",
                                               testName));
        end
    endtask

    initial begin
        lfsrState = 32'h8b7d;
        ctrl      = 1'b0;
        arstN     = 1'b0;
        stall     = 1'b0;
        clear     = 1'b0;
        readQueue = 2'd0;
        readPtr   = '0;
        for (int l = 0; l < LANES; l++) begin
            opValid[l] = 1'b0;
            randomOp(l);
        end
        // The first edge after reset loads these idle inputs
        loadModel();
        for (int b = 0; b < QUEUE_CLASSES; b++) begin
            for (int e = 0; e < DEPTH; e++) begin
                mirrorBank[b][e] = '0;
            end
        end
        repeat (10) @(posedge ctrl);
        @(negedge ctrl);
        arstN = 1'b1;

        readAll("resetState");
        scoreboard.endTest("resetState");

        stepCycle("strobeTiming", 2'b11, 1'b0, 1'b0, 1'b0, 2'd0, 4'd0);
        stepCycle("strobeTiming", 2'b00, 1'b0, 1'b0, 1'b0, 2'd0, 4'd0);
        stepCycle("strobeTiming", 2'b00, 1'b0, 1'b0, 1'b0, 2'd0, 4'd0);
        scoreboard.endTest("strobeTiming");

        repeat (80) begin
            stepCycle("randomOps", 2'(takeBits(2)), 1'b0, takeBits(2) == 0, takeBits(3) == 0,
                      2'(takeBits(2) % 3), 4'(takeBits(4)));
        end
        readAll("randomOps");
        scoreboard.endTest("randomOps");

        stepCycle("stallClear", 2'b11, 1'b0, 1'b0, 1'b0, 2'd0, 4'd0);
        repeat (3) stepCycle("stallClear", 2'b00, 1'b0, 1'b1, 1'b0, 2'd0, 4'd0);
        waitForWrite("stallClear");
        stepCycle("stallClear", 2'b11, 1'b0, 1'b0, 1'b0, 2'd0, 4'd0);
        stepCycle("stallClear", 2'b00, 1'b0, 1'b0, 1'b1, 2'd0, 4'd0);
        readAll("stallClear");
        scoreboard.endTest("stallClear");

        repeat (4) stepCycle("laneCollision", 2'b11, 1'b1, 1'b0, 1'b0, 2'd0, 4'd0);
        readAll("laneCollision");
        scoreboard.endTest("laneCollision");

        @(negedge ctrl);
        scoreboard.printSummary();
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
`default_nettype wire

// File: src.f
microOpPkg.sv
schedulerPkg.sv
dispatchPipeReg.sv
entryFormatter.sv
issueQueuePayload.sv
dispatchTop.sv
dispatch_sva.sv
dispatchChecker.sv
tbDispatch.sv

// File: Makefile
# Verilator build and run of the dispatch stage testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tbDispatch -Mdir obj_dir -o simDispatch -f src.f

run: compile
	./obj_dir/simDispatch | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log
